// File: filelist.f
+incdir+logic
+incdir+testbench
logic/vdiv_op_pkg.sv
logic/vdiv_data_pkg.sv
logic/vdiv_operand_prep.sv
logic/vdiv_stage_reg.sv
logic/vdiv_serial_divider.sv
logic/vdiv_result_fixup.sv
logic/vdiv_top.sv
testbench/vdiv_tb.sv

// File: logic/vdiv_data_pkg.sv
/*
 * data carried between the divider stages
 * lane i of a vector occupies bits [i*w +: w] for element width w
 */

`include "vdiv_defs.svh"

package vdiv_data_pkg;

  typedef logic [`VDIV_XLEN-1:0]      vec_t;
  typedef logic [`VDIV_MAX_LANES-1:0] lane_mask_t;

  // operands after sign handling, waiting for the serial divider
  typedef struct packed {
    vdiv_op_pkg::op_e  op;
    vdiv_op_pkg::sew_e sew;
    vec_t              dvd_mag;
    vec_t              dvs_mag;
    vec_t              dvd_raw;
    lane_mask_t        neg_quo;
    lane_mask_t        neg_rem;
    lane_mask_t        div_zero;
  } prep_payload_t;

  // unsigned results, waiting for sign and zero-divisor fixup
  typedef struct packed {
    vdiv_op_pkg::op_e  op;
    vdiv_op_pkg::sew_e sew;
    vec_t              quo;
    vec_t              rem;
    vec_t              dvd_raw;
    lane_mask_t        neg_quo;
    lane_mask_t        neg_rem;
    lane_mask_t        div_zero;
  } raw_payload_t;

  // two's complement of every lane, the carry chain restarts at each lane boundary
  function automatic vec_t lane_negate(vec_t x, vdiv_op_pkg::sew_e sew);
    vec_t        neg;
    logic        carry;
    int unsigned w;
    w     = vdiv_op_pkg::lane_width(sew);
    carry = 1'b0;
    for (int b = 0; b < `VDIV_XLEN; b++) begin
      if ((b & (w - 1)) == 0) begin
        carry = 1'b1;
      end
      neg[b] = ~x[b] ^ carry;
      carry  = ~x[b] & carry;
    end
    return neg;
  endfunction

endpackage

// File: logic/vdiv_defs.svh
/*
 * shared sizing constants for the SIMD divider
 * the data path is fixed at 64 bits and the divider retires 2 quotient bits per cycle
 */

`ifndef VDIV_DEFS_SVH
`define VDIV_DEFS_SVH

// ------------------------------------------------------------
// data path sizing
// ------------------------------------------------------------

// width of one operand or result vector
`define VDIV_XLEN 64

// lane count at the narrowest element width
`define VDIV_MAX_LANES 8

// restoring steps done in one divider cycle
`define VDIV_BITS_PER_CYCLE 2

`endif

// File: logic/vdiv_op_pkg.sv
/*
 * operation and element width encodings of the divider
 * element widths are powers of two from 8 to 64 bits
 */

`include "vdiv_defs.svh"

package vdiv_op_pkg;

  typedef enum logic [1:0] {
    OP_DIVU,
    OP_DIV,
    OP_REMU,
    OP_REM
  } op_e;

  typedef enum logic [1:0] {
    SEW_8,
    SEW_16,
    SEW_32,
    SEW_64
  } sew_e;

  // log2 of the element width, 3 for 8-bit lanes
  function automatic int unsigned lane_shift(sew_e sew);
    return 3 + int'(sew);
  endfunction

  function automatic int unsigned lane_width(sew_e sew);
    return 1 << lane_shift(sew);
  endfunction

  function automatic int unsigned lane_count(sew_e sew);
    return `VDIV_XLEN / lane_width(sew);
  endfunction

  function automatic logic is_signed_op(op_e op);
    return (op == OP_DIV) || (op == OP_REM);
  endfunction

  function automatic logic is_quotient_op(op_e op);
    return (op == OP_DIVU) || (op == OP_DIV);
  endfunction

endpackage

// File: logic/vdiv_operand_prep.sv
/*
 * combinational front end of the divider
 * sign masks are only set for signed operations, so later stages never check signedness
 */

`include "vdiv_defs.svh"

module vdiv_operand_prep (
  input  vdiv_op_pkg::op_e             op_i,
  input  vdiv_op_pkg::sew_e            sew_i,
  input  vdiv_data_pkg::vec_t          vs1_i,
  input  vdiv_data_pkg::vec_t          vs2_i,
  output vdiv_data_pkg::prep_payload_t payload_o
);

  vdiv_data_pkg::vec_t       vs1_neg;
  vdiv_data_pkg::vec_t       vs2_neg;
  vdiv_data_pkg::lane_mask_t vs1_sign;
  vdiv_data_pkg::lane_mask_t vs2_sign;
  vdiv_data_pkg::lane_mask_t vs1_nonzero;
  vdiv_data_pkg::lane_mask_t vs1_zero;

  always_comb begin
    int unsigned w;
    int unsigned sh;
    int unsigned lane;
    logic        signed_op;
    w         = vdiv_op_pkg::lane_width(sew_i);
    sh        = vdiv_op_pkg::lane_shift(sew_i);
    signed_op = vdiv_op_pkg::is_signed_op(op_i);
    vs1_neg   = vdiv_data_pkg::lane_negate(vs1_i, sew_i);
    vs2_neg   = vdiv_data_pkg::lane_negate(vs2_i, sew_i);

    vs1_sign    = '0;
    vs2_sign    = '0;
    vs1_nonzero = '0;
    vs1_zero    = '0;

    // lanes beyond the lane count are never reached, so their flags stay clear
    for (int b = 0; b < `VDIV_XLEN; b++) begin
      lane              = b >> sh;
      vs1_nonzero[lane] = vs1_nonzero[lane] | vs1_i[b];
      if (((b + 1) & (w - 1)) == 0) begin
        vs1_sign[lane] = signed_op & vs1_i[b];
        vs2_sign[lane] = signed_op & vs2_i[b];
        vs1_zero[lane] = ~vs1_nonzero[lane];
      end
    end

    for (int b = 0; b < `VDIV_XLEN; b++) begin
      lane                 = b >> sh;
      payload_o.dvs_mag[b] = vs1_sign[lane] ? vs1_neg[b] : vs1_i[b];
      payload_o.dvd_mag[b] = vs2_sign[lane] ? vs2_neg[b] : vs2_i[b];
    end

    payload_o.op       = op_i;
    payload_o.sew      = sew_i;
    payload_o.dvd_raw  = vs2_i;
    payload_o.neg_quo  = vs1_sign ^ vs2_sign;
    payload_o.neg_rem  = vs2_sign;
    payload_o.div_zero = vs1_zero;
  end

endmodule

// File: logic/vdiv_result_fixup.sv
/*
 * final stage, applies lane signs and zero-divisor results and drives the result side
 * result_o only holds meaning while res_req_o is high
 */

`include "vdiv_defs.svh"

module vdiv_result_fixup (
  input  logic                        clk_i,
  input  logic                        rstn_i,
  input  logic                        valid_i,
  input  vdiv_data_pkg::raw_payload_t payload_i,
  output logic                        ready_o,
  output logic                        res_req_o,
  output vdiv_data_pkg::vec_t         result_o,
  input  logic                        res_ack_i
);

  vdiv_data_pkg::vec_t quo_neg;
  vdiv_data_pkg::vec_t rem_neg;
  vdiv_data_pkg::vec_t quo_fix;
  vdiv_data_pkg::vec_t rem_fix;
  vdiv_data_pkg::vec_t result_q;
  logic                res_req_q;

  always_comb begin
    int unsigned sh;
    int unsigned lane;
    sh      = vdiv_op_pkg::lane_shift(payload_i.sew);
    quo_neg = vdiv_data_pkg::lane_negate(payload_i.quo, payload_i.sew);
    rem_neg = vdiv_data_pkg::lane_negate(payload_i.rem, payload_i.sew);
    for (int b = 0; b < `VDIV_XLEN; b++) begin
      lane = b >> sh;
      if (payload_i.div_zero[lane]) begin
        quo_fix[b] = 1'b1;
        rem_fix[b] = payload_i.dvd_raw[b];
      end else begin
        quo_fix[b] = payload_i.neg_quo[lane] ? quo_neg[b] : payload_i.quo[b];
        rem_fix[b] = payload_i.neg_rem[lane] ? rem_neg[b] : payload_i.rem[b];
      end
    end
  end

  // ------------------------------------------------------------
  // four-phase result handshake
  // ------------------------------------------------------------

  // a new result waits until the previous acknowledge has been seen low
  assign ready_o   = ~res_req_q & ~res_ack_i;
  assign res_req_o = res_req_q;
  assign result_o  = result_q;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      res_req_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      res_req_q <= 1'b1;
    end else if (res_req_q && res_ack_i) begin
      res_req_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      result_q <= vdiv_op_pkg::is_quotient_op(payload_i.op) ? quo_fix : rem_fix;
    end
  end

endmodule

// File: logic/vdiv_serial_divider.sv
/*
 * restoring divider shared by all lanes, lanes are worked from lane 0 upward
 * each lane costs one load cycle plus width/2 divide cycles
 * a zero divisor gives a meaningless lane result that the fixup stage replaces
 */

`include "vdiv_defs.svh"

module vdiv_serial_divider (
  input  logic                         clk_i,
  input  logic                         rstn_i,
  input  logic                         valid_i,
  input  vdiv_data_pkg::prep_payload_t payload_i,
  output logic                         ready_o,
  output logic                         valid_o,
  output vdiv_data_pkg::raw_payload_t  payload_o,
  input  logic                         ready_i
);

  localparam int unsigned XLEN   = `VDIV_XLEN;
  localparam int unsigned STEPS  = `VDIV_BITS_PER_CYCLE;
  localparam int unsigned LANE_W = $clog2(`VDIV_MAX_LANES);
  localparam int unsigned STEP_W = $clog2(XLEN / STEPS) + 1;

  vdiv_data_pkg::prep_payload_t job_q;
  logic                         busy_q;
  logic                         load_q;
  logic                         done_q;
  logic [LANE_W-1:0]            lane_q;
  logic [STEP_W-1:0]            step_q;
  logic [LANE_W-1:0]            last_lane;
  int unsigned                  w;

  // partial remainder, shifting dividend/quotient and divisor of the current lane
  logic [XLEN-1:0] rem_q;
  logic [XLEN-1:0] quo_q;
  logic [XLEN-1:0] dvs_q;
  logic [XLEN-1:0] rem_n;
  logic [XLEN-1:0] quo_n;
  logic [XLEN-1:0] dvd_lane;
  logic [XLEN-1:0] dvs_lane;
  logic [XLEN-1:0] quo_vec_q;
  logic [XLEN-1:0] rem_vec_q;
  logic            lane_end;

  assign w         = vdiv_op_pkg::lane_width(job_q.sew);
  assign last_lane = LANE_W'(vdiv_op_pkg::lane_count(job_q.sew) - 1);
  assign lane_end  = busy_q & ~load_q & (step_q == STEP_W'(1));

  // the dividend is left aligned so its lane MSB enters the remainder first
  assign dvd_lane = (job_q.dvd_mag >> (lane_q * w)) << (XLEN - w);
  assign dvs_lane = (job_q.dvs_mag >> (lane_q * w)) & ({XLEN{1'b1}} >> (XLEN - w));

  // ------------------------------------------------------------
  // restoring steps of one cycle
  // ------------------------------------------------------------
  always_comb begin
    logic [XLEN:0] trial;
    rem_n = rem_q;
    quo_n = quo_q;
    for (int s = 0; s < STEPS; s++) begin
      trial = {rem_n, quo_n[XLEN-1]};
      quo_n = quo_n << 1;
      if (trial >= {1'b0, dvs_q}) begin
        trial    = trial - {1'b0, dvs_q};
        quo_n[0] = 1'b1;
      end
      rem_n = trial[XLEN-1:0];
    end
  end

  assign ready_o = ~busy_q & (~done_q | ready_i);
  assign valid_o = done_q;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      busy_q <= 1'b0;
      load_q <= 1'b0;
      done_q <= 1'b0;
      lane_q <= '0;
      step_q <= '0;
    end else begin
      if (done_q && ready_i) begin
        done_q <= 1'b0;
      end
      if (valid_i && ready_o) begin
        busy_q <= 1'b1;
        load_q <= 1'b1;
        lane_q <= '0;
      end else if (busy_q && load_q) begin
        load_q <= 1'b0;
        step_q <= STEP_W'(w / STEPS);
      end else if (busy_q) begin
        step_q <= step_q - STEP_W'(1);
        if (lane_end && (lane_q == last_lane)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end else if (lane_end) begin
          lane_q <= lane_q + LANE_W'(1);
          load_q <= 1'b1;
        end
      end
    end
  end

  // finished lanes enter at the top and move down, lane 0 ends at the bottom
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      job_q <= payload_i;
    end
    if (busy_q && load_q) begin
      rem_q <= '0;
      quo_q <= dvd_lane;
      dvs_q <= dvs_lane;
    end else if (busy_q) begin
      rem_q <= rem_n;
      quo_q <= quo_n;
    end
    if (lane_end) begin
      quo_vec_q <= (quo_vec_q >> w) | (quo_n << (XLEN - w));
      rem_vec_q <= (rem_vec_q >> w) | (rem_n << (XLEN - w));
    end
  end

  assign payload_o.op       = job_q.op;
  assign payload_o.sew      = job_q.sew;
  assign payload_o.quo      = quo_vec_q;
  assign payload_o.rem      = rem_vec_q;
  assign payload_o.dvd_raw  = job_q.dvd_raw;
  assign payload_o.neg_quo  = job_q.neg_quo;
  assign payload_o.neg_rem  = job_q.neg_rem;
  assign payload_o.div_zero = job_q.div_zero;

endmodule

// File: logic/vdiv_stage_reg.sv
/*
 * one-entry pipeline slot with a valid/ready pair on both sides
 * ready_o depends combinationally on ready_i so a full slot can refill while it drains
 */

module vdiv_stage_reg #(
  parameter type PAYLOAD_T = logic
) (
  input  logic     clk_i,
  input  logic     rstn_i,
  input  logic     valid_i,
  input  PAYLOAD_T payload_i,
  output logic     ready_o,
  output logic     valid_o,
  output PAYLOAD_T payload_o,
  input  logic     ready_i
);

  logic     full_q;
  PAYLOAD_T data_q;

  assign ready_o   = ~full_q | ready_i;
  assign valid_o   = full_q;
  assign payload_o = data_q;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      full_q <= 1'b0;
    end else if (ready_o) begin
      full_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= payload_i;
    end
  end

endmodule

// File: logic/vdiv_top.sv
/*
 * SIMD integer divider with four-phase handshakes on the operand and result sides
 * operands must stay stable while req_i is high, up to four operations can be in flight
 */

module vdiv_top (
  input  logic                clk_i,
  input  logic                rstn_i,
  input  logic                req_i,
  input  vdiv_op_pkg::op_e    op_i,
  input  vdiv_op_pkg::sew_e   sew_i,
  input  vdiv_data_pkg::vec_t vs1_i,
  input  vdiv_data_pkg::vec_t vs2_i,
  output logic                ack_o,
  output logic                res_req_o,
  output vdiv_data_pkg::vec_t result_o,
  input  logic                res_ack_i
);

  vdiv_data_pkg::prep_payload_t prep_payload;
  vdiv_data_pkg::prep_payload_t prep_slot_payload;
  vdiv_data_pkg::raw_payload_t  div_payload;
  vdiv_data_pkg::raw_payload_t  raw_slot_payload;
  logic                         ack_q;
  logic                         in_valid;
  logic                         prep_ready;
  logic                         prep_slot_valid;
  logic                         div_ready;
  logic                         div_valid;
  logic                         raw_ready;
  logic                         raw_slot_valid;
  logic                         fixup_ready;

  // ------------------------------------------------------------
  // operand handshake
  // ------------------------------------------------------------

  // a raised req_i offers one operation, ack_q blocks it from being taken twice
  assign in_valid = req_i & ~ack_q;
  assign ack_o    = ack_q;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      ack_q <= 1'b0;
    end else if (in_valid && prep_ready) begin
      ack_q <= 1'b1;
    end else if (ack_q && !req_i) begin
      ack_q <= 1'b0;
    end
  end

  vdiv_operand_prep operand_prep_inst (
    .op_i      (op_i),
    .sew_i     (sew_i),
    .vs1_i     (vs1_i),
    .vs2_i     (vs2_i),
    .payload_o (prep_payload)
  );

  vdiv_stage_reg #(
    .PAYLOAD_T (vdiv_data_pkg::prep_payload_t)
  ) prep_slot (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .valid_i   (in_valid),
    .payload_i (prep_payload),
    .ready_o   (prep_ready),
    .valid_o   (prep_slot_valid),
    .payload_o (prep_slot_payload),
    .ready_i   (div_ready)
  );

  vdiv_serial_divider serial_divider_inst (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .valid_i   (prep_slot_valid),
    .payload_i (prep_slot_payload),
    .ready_o   (div_ready),
    .valid_o   (div_valid),
    .payload_o (div_payload),
    .ready_i   (raw_ready)
  );

  vdiv_stage_reg #(
    .PAYLOAD_T (vdiv_data_pkg::raw_payload_t)
  ) raw_slot (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .valid_i   (div_valid),
    .payload_i (div_payload),
    .ready_o   (raw_ready),
    .valid_o   (raw_slot_valid),
    .payload_o (raw_slot_payload),
    .ready_i   (fixup_ready)
  );

  vdiv_result_fixup result_fixup_inst (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .valid_i   (raw_slot_valid),
    .payload_i (raw_slot_payload),
    .ready_o   (fixup_ready),
    .res_req_o (res_req_o),
    .result_o  (result_o),
    .res_ack_i (res_ack_i)
  );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds the divider testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module vdiv_tb -o vdiv_sim

./obj_dir/vdiv_sim | tee sim.log

if grep -q "Regression passed" sim.log; then
  echo "simulation PASS"
  exit 0
else
  echo "simulation FAIL, see sim.log"
  exit 1
fi

// File: testbench/vdiv_model.svh
/*
 * reference model and random source for the divider testbench, included inside the module
 * lanes are handled as zero-extended 64-bit values, w is the lane width in bits
 */

`ifndef VDIV_MODEL_SVH
`define VDIV_MODEL_SVH

// 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
  logic fb;
  fb = state[15] ^ state[13] ^ state[12] ^ state[10];
  return {state[14:0], fb};
endfunction

// one LFSR step per bit taken, the newest bit lands in the LSB
function automatic logic [63:0] take_bits(inout logic [15:0] state, input int n);
  logic [63:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    state = lfsr_next(state);
    r     = {r[62:0], state[0]};
  end
  return r;
endfunction

function automatic logic [63:0] lane_ones(input int w);
  return (w == 64) ? {64{1'b1}} : ((64'd1 << w) - 64'd1);
endfunction

// ------------------------------------------------------------
// one lane, sign and magnitude, truncating toward zero
// ------------------------------------------------------------
function automatic logic [63:0] model_lane(input vdiv_op_pkg::op_e op, input int w,
                                           input logic [63:0] dvd, input logic [63:0] dvs);
  logic [63:0] mask;
  logic [63:0] ma;
  logic [63:0] mb;
  logic [63:0] q;
  logic [63:0] r;
  logic        signed_op;
  logic        sa;
  logic        sb;
  mask      = lane_ones(w);
  signed_op = (op == vdiv_op_pkg::OP_DIV) || (op == vdiv_op_pkg::OP_REM);
  sa        = signed_op & dvd[w-1];
  sb        = signed_op & dvs[w-1];
  ma        = sa ? ((~dvd + 64'd1) & mask) : dvd;
  mb        = sb ? ((~dvs + 64'd1) & mask) : dvs;
  if (dvs == 64'd0) begin
    q = mask;
    r = dvd;
  end else begin
    q = ma / mb;
    r = ma % mb;
    // the remainder follows the dividend sign
    if (sa ^ sb) begin
      q = (~q + 64'd1) & mask;
    end
    if (sa) begin
      r = (~r + 64'd1) & mask;
    end
  end
  return ((op == vdiv_op_pkg::OP_DIVU) || (op == vdiv_op_pkg::OP_DIV)) ? q : r;
endfunction

function automatic vdiv_data_pkg::vec_t model_vector(input vdiv_op_pkg::op_e op,
                                                     input vdiv_op_pkg::sew_e sew,
                                                     input vdiv_data_pkg::vec_t vs1,
                                                     input vdiv_data_pkg::vec_t vs2);
  vdiv_data_pkg::vec_t res;
  logic [63:0]         mask;
  logic [63:0]         a;
  logic [63:0]         b;
  int                  w;
  w    = 8 << int'(sew);
  mask = lane_ones(w);
  res  = '0;
  for (int i = 0; i < 64 / w; i++) begin
    a   = (vs2 >> (i * w)) & mask;
    b   = (vs1 >> (i * w)) & mask;
    res = res | (model_lane(op, w, a, b) << (i * w));
  end
  return res;
endfunction

`endif

// File: testbench/vdiv_tb.sv
/*
 * random regression for the SIMD divider against the model in vdiv_model.svh
 * a request process and a result process run in parallel, results must come back in order
 */

module vdiv_tb;

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int DIRECTED_OPS   = 16;
  localparam int RANDOM_OPS     = 200;
  localparam int SIG_ACK        = 0;
  localparam int SIG_RES_REQ    = 1;

  logic                clk_i;
  logic                rstn_i;
  logic                req_i;
  vdiv_op_pkg::op_e    op_i;
  vdiv_op_pkg::sew_e   sew_i;
  vdiv_data_pkg::vec_t vs1_i;
  vdiv_data_pkg::vec_t vs2_i;
  logic                ack_o;
  logic                res_req_o;
  vdiv_data_pkg::vec_t result_o;
  logic                res_ack_i;

  logic [15:0]         stim_state;
  logic [15:0]         delay_state;
  vdiv_data_pkg::vec_t expected_q[$];
  int                  result_errors;
  int                  handshake_errors;
  int                  timeout_count;
  logic                timed_out;

  `include "vdiv_model.svh"

  vdiv_top vdiv_top_inst (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .req_i     (req_i),
    .op_i      (op_i),
    .sew_i     (sew_i),
    .vs1_i     (vs1_i),
    .vs2_i     (vs2_i),
    .ack_o     (ack_o),
    .res_req_o (res_req_o),
    .result_o  (result_o),
    .res_ack_i (res_ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // checks and waits
  // ------------------------------------------------------------
  task automatic check_result(input vdiv_data_pkg::vec_t got, input vdiv_data_pkg::vec_t exp,
                              input string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      result_errors++;
    end
  endtask

  task automatic check_handshake(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      handshake_errors++;
    end
  endtask

  function automatic logic probe(input int sig);
    return (sig == SIG_ACK) ? ack_o : res_req_o;
  endfunction

  // outputs are sampled on the falling edge, half a cycle after they change
  task automatic wait_for(input int sig, input logic level, input string what);
    int cycles;
    cycles = 0;
    if (timed_out) begin
      return;
    end
    @(negedge clk_i);
    while (probe(sig) !== level) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
        timeout_count++;
        timed_out = 1'b1;
        return;
      end
      @(negedge clk_i);
    end
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  // zero, -1 and the most negative value are forced now and then
  function automatic logic [63:0] random_lane(input int w, input logic divisor);
    logic [2:0] pick;
    pick = 3'(take_bits(stim_state, 3));
    case (pick)
      3'd0:    return 64'd0;
      3'd1:    return lane_ones(w);
      3'd2:    return 64'd1 << (w - 1);
      3'd3:    return divisor ? take_bits(stim_state, 3) : take_bits(stim_state, w);
      default: return take_bits(stim_state, w);
    endcase
  endfunction

  function automatic vdiv_data_pkg::vec_t random_vector(input vdiv_op_pkg::sew_e sew,
                                                        input logic divisor);
    vdiv_data_pkg::vec_t v;
    int                  w;
    w = 8 << int'(sew);
    v = '0;
    for (int i = 0; i < 64 / w; i++) begin
      v = v | (random_lane(w, divisor) << (i * w));
    end
    return v;
  endfunction

  function automatic vdiv_data_pkg::vec_t fill_vector(input vdiv_op_pkg::sew_e sew,
                                                      input logic [63:0] val,
                                                      input logic odd_only);
    vdiv_data_pkg::vec_t v;
    int                  w;
    w = 8 << int'(sew);
    v = '0;
    for (int i = 0; i < 64 / w; i++) begin
      if (!odd_only || (i % 2 == 1)) begin
        v = v | ((val & lane_ones(w)) << (i * w));
      end
    end
    return v;
  endfunction

  task automatic send_op(input vdiv_op_pkg::op_e op, input vdiv_op_pkg::sew_e sew,
                         input vdiv_data_pkg::vec_t vs1, input vdiv_data_pkg::vec_t vs2);
    if (timed_out) begin
      return;
    end
    expected_q.push_back(model_vector(op, sew, vs1, vs2));
    @(posedge clk_i);
    req_i <= 1'b1;
    op_i  <= op;
    sew_i <= sew;
    vs1_i <= vs1;
    vs2_i <= vs2;
    wait_for(SIG_ACK, 1'b1, "ack_o to rise");
    if (timed_out) begin
      return;
    end
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    check_handshake(ack_o, 1'b1, "ack_o before req_i is seen low");
    wait_for(SIG_ACK, 1'b0, "ack_o to fall");
  endtask

  task automatic drive_requests();
    vdiv_op_pkg::op_e  op;
    vdiv_op_pkg::sew_e sew;
    vdiv_data_pkg::vec_t most_neg;
    for (int s = 0; s < 4; s++) begin
      sew      = vdiv_op_pkg::sew_e'(2'(s));
      most_neg = fill_vector(sew, 64'd1 << ((8 << s) - 1), 1'b0);
      send_op(vdiv_op_pkg::OP_DIV, sew, fill_vector(sew, {64{1'b1}}, 1'b0), most_neg);
      send_op(vdiv_op_pkg::OP_REM, sew, fill_vector(sew, {64{1'b1}}, 1'b0), most_neg);
      // even lanes divide by zero while odd lanes divide by 3
      send_op(vdiv_op_pkg::OP_DIVU, sew, fill_vector(sew, 64'd3, 1'b1),
              random_vector(sew, 1'b0));
      send_op(vdiv_op_pkg::OP_REM, sew, fill_vector(sew, 64'd3, 1'b1),
              random_vector(sew, 1'b0));
    end
    for (int n = 0; n < RANDOM_OPS; n++) begin
      op  = vdiv_op_pkg::op_e'(2'(take_bits(stim_state, 2)));
      sew = vdiv_op_pkg::sew_e'(2'(take_bits(stim_state, 2)));
      send_op(op, sew, random_vector(sew, 1'b1), random_vector(sew, 1'b0));
      if (take_bits(stim_state, 2) == 64'd3) begin
        repeat (6) @(posedge clk_i);
      end
    end
  endtask

  // ------------------------------------------------------------
  // result side
  // ------------------------------------------------------------
  task automatic collect_results();
    vdiv_data_pkg::vec_t expected;
    int                  delay;
    for (int n = 0; n < DIRECTED_OPS + RANDOM_OPS; n++) begin
      wait_for(SIG_RES_REQ, 1'b1, "res_req_o to rise");
      if (timed_out) begin
        break;
      end
      if (expected_q.size() == 0) begin
        $display("result %0d arrived with no operation outstanding", n);
        handshake_errors++;
        break;
      end
      expected = expected_q.pop_front();
      check_result(result_o, expected, "result_o");
      // long stalls let the pipeline fill up behind the held result
      delay = int'(take_bits(delay_state, 3));
      if (take_bits(delay_state, 2) == 64'd0) begin
        delay = delay + 40;
      end
      repeat (delay) begin
        @(negedge clk_i);
        check_handshake(res_req_o, 1'b1, "res_req_o before res_ack_i");
        check_result(result_o, expected, "held result_o");
      end
      @(posedge clk_i);
      res_ack_i <= 1'b1;
      @(negedge clk_i);
      check_handshake(res_req_o, 1'b1, "res_req_o before res_ack_i is seen high");
      wait_for(SIG_RES_REQ, 1'b0, "res_req_o to fall");
      if (timed_out) begin
        break;
      end
      @(posedge clk_i);
      res_ack_i <= 1'b0;
    end
  endtask

  initial begin
    rstn_i           = 1'b0;
    req_i            = 1'b0;
    op_i             = vdiv_op_pkg::OP_DIVU;
    sew_i            = vdiv_op_pkg::SEW_8;
    vs1_i            = '0;
    vs2_i            = '0;
    res_ack_i        = 1'b0;
    stim_state       = 16'd98;
    delay_state      = 16'd98;
    result_errors    = 0;
    handshake_errors = 0;
    timeout_count    = 0;
    timed_out        = 1'b0;
    repeat (10) @(posedge clk_i);
    rstn_i <= 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_handshake(ack_o, 1'b0, "ack_o after reset");
      check_handshake(res_req_o, 1'b0, "res_req_o after reset");
    end
    fork
      drive_requests();
      collect_results();
    join
    // a stray extra result would show up here
    repeat (100) begin
      @(negedge clk_i);
      check_handshake(res_req_o, 1'b0, "res_req_o after the last result");
    end
    $display("errors: result %0d, handshake %0d, timeouts %0d, unreturned %0d",
             result_errors, handshake_errors, timeout_count, expected_q.size());
    if ((result_errors == 0) && (handshake_errors == 0) && (timeout_count == 0) &&
        (expected_q.size() == 0)) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
